// ==== logic/fib_params.svh ====
`ifndef FIB_PARAMS_SVH
`define FIB_PARAMS_SVH

// Name prefix width, counted from the most significant bit
`define FIB_PREFIX_W 64

// Prefix length in bits, 0 to 63
`define FIB_LEN_W 6

// Face identifier width
`define FIB_FACE_W 8

// Payload byte carried with a data packet
`define FIB_PAYLOAD_W 8

// Route table size
`define FIB_DEPTH 8

// Entry index width, log2 of the depth
`define FIB_INDEX_W 3

`endif

// ==== logic/fib_pkg.sv ====
`default_nettype none

`include "fib_params.svh"

package fib_pkg;

    // Interest or data name
    typedef struct packed {
        logic [`FIB_PREFIX_W-1:0] prefix;
        logic [`FIB_LEN_W-1:0]    len;
    } fib_name_t;

    // One stored route
    typedef struct packed {
        logic                   valid;
        fib_name_t              name;
        logic [`FIB_FACE_W-1:0] face;
    } fib_entry_t;

    // Lookup answer returned to the PIT
    typedef struct packed {
        logic                   hit;
        fib_name_t              name;
        logic [`FIB_FACE_W-1:0] face;
    } fib_result_t;

    // Incoming data packet as captured from the PIT side
    typedef struct packed {
        fib_name_t                 name;
        logic [`FIB_PAYLOAD_W-1:0] payload;
        logic [`FIB_FACE_W-1:0]    face;
    } fib_data_t;

    // Route learn request into the table
    typedef struct packed {
        logic                   wr;
        fib_name_t              name;
        logic [`FIB_FACE_W-1:0] face;
    } fib_install_t;

    // Ones in the top len bits, zeros below; len 0 gives all zeros
    function automatic logic [`FIB_PREFIX_W-1:0] prefix_mask(input logic [`FIB_LEN_W-1:0] len);
        prefix_mask = ~({`FIB_PREFIX_W{1'b1}} >> len);
    endfunction

endpackage

`default_nettype wire

// ==== logic/fib_route_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fib_params.svh"

module fib_route_table (
    input  logic                    clk,
    input  logic                    reset,
    input  fib_pkg::fib_install_t   install,
    input  logic [`FIB_INDEX_W-1:0] rd_index,
    output fib_pkg::fib_entry_t     rd_entry
);

    logic [`FIB_DEPTH-1:0]   valid_q;
    fib_pkg::fib_name_t      name_q [`FIB_DEPTH];
    logic [`FIB_FACE_W-1:0]  face_q [`FIB_DEPTH];
    logic [`FIB_INDEX_W-1:0] victim;

    fib_pkg::fib_name_t      wr_name;
    logic                    same_hit;
    logic [`FIB_INDEX_W-1:0] same_idx;
    logic                    free_hit;
    logic [`FIB_INDEX_W-1:0] free_idx;
    logic [`FIB_INDEX_W-1:0] wr_idx;
    logic [`FIB_INDEX_W-1:0] victim_next;

    // Stored prefixes carry zeros below their length
    assign wr_name = '{
        prefix: install.name.prefix & fib_pkg::prefix_mask(install.name.len),
        len:    install.name.len
    };

    // Existing route with the same name, and the lowest free slot
    always_comb begin
        same_hit = 1'b0;
        same_idx = '0;
        free_hit = 1'b0;
        free_idx = '0;
        for (int i = 0; i < `FIB_DEPTH; i++) begin
            if (!same_hit && valid_q[i] && name_q[i] == wr_name) begin
                same_hit = 1'b1;
                same_idx = `FIB_INDEX_W'(i);
            end
            if (!free_hit && !valid_q[i]) begin
                free_hit = 1'b1;
                free_idx = `FIB_INDEX_W'(i);
            end
        end
    end

    // Update in place, then free slot, then round-robin victim
    assign wr_idx = same_hit ? same_idx :
                    free_hit ? free_idx : victim;

    assign victim_next = (victim == `FIB_INDEX_W'(`FIB_DEPTH - 1)) ? '0 : victim + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            victim  <= '0;
        end else if (install.wr && !same_hit) begin
            valid_q[wr_idx] <= 1'b1;
            if (!free_hit) begin
                victim <= victim_next;
            end
        end
    end

    // Face always rewritten; name only when a new slot is claimed
    always_ff @(posedge clk) begin
        if (install.wr) begin
            face_q[wr_idx] <= install.face;
            if (!same_hit) begin
                name_q[wr_idx] <= wr_name;
            end
        end
    end

    // Combinational read for the search engine
    assign rd_entry = '{
        valid: valid_q[rd_index],
        name:  name_q[rd_index],
        face:  face_q[rd_index]
    };

endmodule

`default_nettype wire

// ==== logic/fib_lpm_search.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fib_params.svh"

module fib_lpm_search (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fib_out_bit,
    input  fib_pkg::fib_name_t      pit_in_name,
    input  fib_pkg::fib_entry_t     rd_entry,
    output logic [`FIB_INDEX_W-1:0] rd_index,
    output logic                    lookup_busy,
    output logic                    lookup_done,
    output fib_pkg::fib_result_t    longest_match
);

    fib_pkg::fib_name_t   key;
    fib_pkg::fib_result_t best;
    fib_pkg::fib_result_t cand;
    logic                 start;
    logic                 last_step;
    logic                 entry_match;
    logic                 take_entry;

    // Strobe only counts while idle
    assign start     = fib_out_bit && !lookup_busy;
    assign last_step = (rd_index == `FIB_INDEX_W'(`FIB_DEPTH - 1));

    // Entry prefix must cover the key's top bits up to the entry length
    always_comb begin
        entry_match = rd_entry.valid &&
                      (rd_entry.name.len <= key.len) &&
                      (((rd_entry.name.prefix ^ key.prefix) &
                        fib_pkg::prefix_mask(rd_entry.name.len)) == '0);

        // Strictly longer wins, so the earlier index keeps ties
        take_entry = entry_match && (!best.hit || rd_entry.name.len > best.name.len);

        if (take_entry) begin
            cand = '{hit: 1'b1, name: rd_entry.name, face: rd_entry.face};
        end else begin
            cand = best;
        end
    end

    // Scan sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_busy       <= 1'b0;
            lookup_done       <= 1'b0;
            rd_index          <= '0;
            longest_match.hit <= 1'b0;
        end else begin
            lookup_done <= 1'b0;
            if (start) begin
                lookup_busy <= 1'b1;
                rd_index    <= '0;
            end else if (lookup_busy) begin
                if (last_step) begin
                    lookup_busy   <= 1'b0;
                    lookup_done   <= 1'b1;
                    longest_match <= cand;
                end else begin
                    rd_index <= rd_index + 1'b1;
                end
            end
        end
    end

    // Key and running best candidate
    always_ff @(posedge clk) begin
        if (start) begin
            key  <= pit_in_name;
            best <= '0;
        end else if (lookup_busy) begin
            best <= cand;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fib_data_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fib_params.svh"

module fib_data_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      data_ready,
    input  fib_pkg::fib_data_t        data_in,
    input  logic                      rejected,
    input  logic                      start_send_to_pit,
    output logic                      prefix_ready,
    output fib_pkg::fib_name_t        pit_out_name,
    output logic [`FIB_PAYLOAD_W-1:0] out_data,
    output fib_pkg::fib_install_t     install
);

    fib_pkg::fib_data_t held;
    logic               capture;
    logic               decided;

    // Idle takes a new packet, waiting takes the PIT answer
    assign capture = data_ready && !prefix_ready;
    assign decided = prefix_ready && (rejected || start_send_to_pit);

    always_ff @(posedge clk) begin
        if (reset) begin
            prefix_ready <= 1'b0;
            install.wr   <= 1'b0;
        end else begin
            install.wr <= 1'b0;
            if (capture) begin
                prefix_ready <= 1'b1;
            end else if (decided) begin
                prefix_ready <= 1'b0;
                // Reject has priority over accept
                install.wr   <= !rejected;
            end
        end
    end

    // Held packet and route request contents
    always_ff @(posedge clk) begin
        if (capture) begin
            held <= data_in;
        end
        if (decided) begin
            install.name <= held.name;
            install.face <= held.face;
        end
    end

    // Presented to the PIT while waiting
    assign pit_out_name = held.name;
    assign out_data     = held.payload;

endmodule

`default_nettype wire

// ==== logic/fib_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fib_params.svh"

module fib_top (
    input  logic                      clk,
    input  logic                      reset,

    // Outgoing interest lookup
    input  logic                      fib_out_bit,
    input  fib_pkg::fib_name_t        pit_in_name,
    output logic                      lookup_busy,
    output logic                      lookup_done,
    output fib_pkg::fib_result_t      longest_match,

    // Incoming data toward the PIT
    input  logic                      data_ready,
    input  fib_pkg::fib_data_t        data_in,
    input  logic                      rejected,
    input  logic                      start_send_to_pit,
    output logic                      prefix_ready,
    output fib_pkg::fib_name_t        pit_out_name,
    output logic [`FIB_PAYLOAD_W-1:0] out_data
);

    fib_pkg::fib_install_t   install;
    fib_pkg::fib_entry_t     rd_entry;
    logic [`FIB_INDEX_W-1:0] rd_index;

    fib_route_table u_table (
        .clk      (clk),
        .reset    (reset),
        .install  (install),
        .rd_index (rd_index),
        .rd_entry (rd_entry)
    );

    fib_lpm_search u_search (
        .clk           (clk),
        .reset         (reset),
        .fib_out_bit   (fib_out_bit),
        .pit_in_name   (pit_in_name),
        .rd_entry      (rd_entry),
        .rd_index      (rd_index),
        .lookup_busy   (lookup_busy),
        .lookup_done   (lookup_done),
        .longest_match (longest_match)
    );

    // Learned routes flow from here into the table
    fib_data_stage u_data (
        .clk               (clk),
        .reset             (reset),
        .data_ready        (data_ready),
        .data_in           (data_in),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .prefix_ready      (prefix_ready),
        .pit_out_name      (pit_out_name),
        .out_data          (out_data),
        .install           (install)
    );

endmodule

`default_nettype wire

// ==== verification/fib_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fib_sva (
    input logic clk,
    input logic reset,
    input logic lookup_busy,
    input logic lookup_done,
    input logic prefix_ready,
    input logic rejected,
    input logic start_send_to_pit
);

    // Done is a single-cycle pulse
    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        lookup_done |=> !lookup_done)
        else $error("lookup_done stayed high for more than one cycle");

    // Done closes a scan
    done_after_busy: assert property (@(posedge clk) disable iff (reset)
        lookup_done |-> $past(lookup_busy))
        else $error("lookup_done without a busy cycle before it");

    // Cleared by the first reset edge
    done_low_in_reset: assert property (@(posedge clk)
        reset |=> !lookup_done)
        else $error("lookup_done high while in reset");

    // Held packet waits for the PIT answer
    prefix_ready_holds: assert property (@(posedge clk) disable iff (reset)
        prefix_ready && !rejected && !start_send_to_pit |=> prefix_ready)
        else $error("prefix_ready dropped without a PIT answer");

endmodule

bind fib_top fib_sva u_sva (
    .clk               (clk),
    .reset             (reset),
    .lookup_busy       (lookup_busy),
    .lookup_done       (lookup_done),
    .prefix_ready      (prefix_ready),
    .rejected          (rejected),
    .start_send_to_pit (start_send_to_pit)
);

`default_nettype wire

// ==== verification/fib_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fib_params.svh"

module fib_tb;

    // Six tests of at most ~40 operations, each up to ~12 cycles, plus margin
    localparam int MAX_CYCLES = 3000;
    localparam int REJECT     = 0;
    localparam int ACCEPT     = 1;
    localparam int BOTH       = 2;
    localparam logic [`FIB_PREFIX_W-1:0] PATH = 64'h1122_3344_5566_7788;

    logic                      clk;
    logic                      reset;
    logic                      fib_out_bit;
    fib_pkg::fib_name_t        pit_in_name;
    logic                      lookup_busy;
    logic                      lookup_done;
    fib_pkg::fib_result_t      longest_match;
    logic                      data_ready;
    fib_pkg::fib_data_t        data_in;
    logic                      rejected;
    logic                      start_send_to_pit;
    logic                      prefix_ready;
    fib_pkg::fib_name_t        pit_out_name;
    logic [`FIB_PAYLOAD_W-1:0] out_data;

    // Reference route table
    logic                     m_valid  [`FIB_DEPTH];
    logic [`FIB_PREFIX_W-1:0] m_prefix [`FIB_DEPTH];
    logic [`FIB_LEN_W-1:0]    m_len    [`FIB_DEPTH];
    logic [`FIB_FACE_W-1:0]   m_face   [`FIB_DEPTH];
    int                       m_victim;

    int seed;
    int cycles = 0;
    int errors;
    int tests_passed;
    int tests_failed;

    fib_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string sig, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("ERROR %s expected %0h actual %0h", sig, exp, act);
        errors++;
    endtask

    // Ones in the top len bits
    function automatic logic [`FIB_PREFIX_W-1:0] len_mask(input int len);
        if (len == 0) begin
            return '0;
        end
        return {`FIB_PREFIX_W{1'b1}} << (`FIB_PREFIX_W - len);
    endfunction

    function automatic fib_pkg::fib_name_t mk_name(input logic [`FIB_PREFIX_W-1:0] prefix,
                                                   input logic [`FIB_LEN_W-1:0] len);
        fib_pkg::fib_name_t n;
        n.prefix = prefix;
        n.len    = len;
        return n;
    endfunction

    function automatic fib_pkg::fib_data_t mk_data(input logic [`FIB_PREFIX_W-1:0] prefix,
                                                   input logic [`FIB_LEN_W-1:0] len,
                                                   input logic [7:0] payload,
                                                   input logic [7:0] face);
        fib_pkg::fib_data_t d;
        d.name    = mk_name(prefix, len);
        d.payload = payload;
        d.face    = face;
        return d;
    endfunction

    // Same name updates face, else first free slot, else round-robin victim
    task automatic model_install(input fib_pkg::fib_name_t name,
                                 input logic [`FIB_FACE_W-1:0] face);
        logic [`FIB_PREFIX_W-1:0] p;
        int slot;
        p = name.prefix & len_mask(int'(name.len));
        slot = -1;
        for (int i = 0; i < `FIB_DEPTH; i++) begin
            if (slot < 0 && m_valid[i] && m_len[i] == name.len && m_prefix[i] == p) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            m_face[slot] = face;
        end else begin
            for (int i = 0; i < `FIB_DEPTH; i++) begin
                if (slot < 0 && !m_valid[i]) begin
                    slot = i;
                end
            end
            if (slot < 0) begin
                slot = m_victim;
                m_victim = (m_victim + 1) % `FIB_DEPTH;
            end
            m_valid[slot]  = 1'b1;
            m_prefix[slot] = p;
            m_len[slot]    = name.len;
            m_face[slot]   = face;
        end
    endtask

    // Longest valid covering route with the lower index kept on ties
    function automatic fib_pkg::fib_result_t expected_match(input fib_pkg::fib_name_t key);
        fib_pkg::fib_result_t r;
        r = '0;
        for (int i = 0; i < `FIB_DEPTH; i++) begin
            if (m_valid[i] && m_len[i] <= key.len &&
                ((m_prefix[i] ^ key.prefix) & len_mask(int'(m_len[i]))) == '0 &&
                (!r.hit || m_len[i] > r.name.len)) begin
                r.hit         = 1'b1;
                r.name.prefix = m_prefix[i];
                r.name.len    = m_len[i];
                r.face        = m_face[i];
            end
        end
        return r;
    endfunction

    task automatic lookup_check(input fib_pkg::fib_name_t key, input bit intrude);
        fib_pkg::fib_result_t exp;
        int n;
        int extra;
        exp = expected_match(key);
        fib_out_bit = 1'b1;
        pit_in_name = key;
        n = 0;
        do begin
            tick();
            n++;
            fib_out_bit = 1'b0;
            // Busy from the edge after the strobe until done
            if (n <= `FIB_DEPTH && lookup_busy !== 1'b1)
                report_mismatch("lookup_busy", 128'(1), 128'(lookup_busy));
            // Strobe in the middle of the scan with a different key
            if (intrude && n == 3) begin
                fib_out_bit        = 1'b1;
                pit_in_name.prefix = ~key.prefix;
            end
        end while (!lookup_done && n < 4 * `FIB_DEPTH);
        if (!lookup_done) begin
            $display("lookup_done never arrived after %0d cycles", n);
            errors++;
        end else begin
            if (n != `FIB_DEPTH + 1)
                report_mismatch("lookup_done latency", 128'(`FIB_DEPTH + 1), 128'(n));
            if (lookup_busy !== 1'b0)
                report_mismatch("lookup_busy", 128'(0), 128'(lookup_busy));
            if (longest_match.hit !== exp.hit)
                report_mismatch("longest_match.hit", 128'(exp.hit), 128'(longest_match.hit));
            if (longest_match.name !== exp.name)
                report_mismatch("longest_match.name", 128'(exp.name), 128'(longest_match.name));
            if (longest_match.face !== exp.face)
                report_mismatch("longest_match.face", 128'(exp.face), 128'(longest_match.face));
        end
        if (intrude) begin
            extra = 0;
            repeat (`FIB_DEPTH + 2) begin
                tick();
                if (lookup_done) extra++;
            end
            if (extra != 0) begin
                $display("Strobe during a busy scan started another lookup");
                errors++;
            end
        end
    endtask

    task automatic present_packet(input fib_pkg::fib_data_t pkt, input int answer);
        data_ready = 1'b1;
        data_in    = pkt;
        tick();
        if (prefix_ready !== 1'b1)
            report_mismatch("prefix_ready", 128'(1), 128'(prefix_ready));
        // Another packet while one is held must be ignored
        data_in.name.prefix = ~pkt.name.prefix;
        data_in.payload     = ~pkt.payload;
        tick();
        data_ready = 1'b0;
        if (pit_out_name !== pkt.name)
            report_mismatch("pit_out_name", 128'(pkt.name), 128'(pit_out_name));
        if (out_data !== pkt.payload)
            report_mismatch("out_data", 128'(pkt.payload), 128'(out_data));
        rejected          = (answer != ACCEPT);
        start_send_to_pit = (answer != REJECT);
        tick();
        rejected          = 1'b0;
        start_send_to_pit = 1'b0;
        if (prefix_ready !== 1'b0)
            report_mismatch("prefix_ready", 128'(0), 128'(prefix_ready));
        // Route lands in the table on this edge
        tick();
        if (answer == ACCEPT) model_install(pkt.name, pkt.face);
    endtask

    task automatic close_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic test_empty_lookup();
        int e;
        e = errors;
        lookup_check(mk_name(64'hDEAD_BEEF_0123_4567, 6'd63), 1'b0);
        lookup_check(mk_name('0, 6'd0), 1'b0);
        close_test("empty table lookup", e);
    endtask

    task automatic test_pit_presentation();
        int e;
        e = errors;
        present_packet(mk_data(64'hC0FF_EE00_1111_2222, 6'd24, 8'h5A, 8'h03), REJECT);
        lookup_check(mk_name(64'hC0FF_EE00_1111_2222, 6'd63), 1'b0);
        present_packet(mk_data(64'hC0FF_EE00_1111_2222, 6'd24, 8'h6B, 8'h04), BOTH);
        lookup_check(mk_name(64'hC0FF_EE00_1111_2222, 6'd63), 1'b0);
        close_test("PIT presentation", e);
    endtask

    task automatic test_learned_route();
        int e;
        e = errors;
        present_packet(mk_data(64'hA5C3_1234_5678_9ABC, 6'd16, 8'h11, 8'h07), ACCEPT);
        lookup_check(mk_name(64'hA5C3_FFFF_0000_0000, 6'd40), 1'b0);
        if (longest_match.name.prefix !== 64'hA5C3_0000_0000_0000)
            report_mismatch("longest_match.name.prefix", 128'(64'hA5C3_0000_0000_0000),
                            128'(longest_match.name.prefix));
        if (longest_match.face !== 8'h07)
            report_mismatch("longest_match.face", 128'(8'h07), 128'(longest_match.face));
        close_test("learned route lookup", e);
    endtask

    task automatic test_longest_match();
        int e;
        e = errors;
        present_packet(mk_data(PATH, 6'd0, 8'h20, 8'h10), ACCEPT);
        present_packet(mk_data(PATH, 6'd8, 8'h21, 8'h11), ACCEPT);
        present_packet(mk_data(PATH, 6'd16, 8'h22, 8'h12), ACCEPT);
        present_packet(mk_data(PATH, 6'd40, 8'h23, 8'h13), ACCEPT);
        lookup_check(mk_name(PATH, 6'd63), 1'b0);
        if (longest_match.face !== 8'h13)
            report_mismatch("longest_match.face", 128'(8'h13), 128'(longest_match.face));
        lookup_check(mk_name(PATH, 6'd39), 1'b0);
        lookup_check(mk_name(PATH, 6'd16), 1'b0);
        lookup_check(mk_name(PATH, 6'd4), 1'b0);
        lookup_check(mk_name(PATH ^ 64'h0000_0000_8000_0000, 6'd63), 1'b0);
        lookup_check(mk_name(PATH ^ 64'h8000_0000_0000_0000, 6'd63), 1'b0);
        if (longest_match.face !== 8'h10)
            report_mismatch("longest_match.face", 128'(8'h10), 128'(longest_match.face));
        close_test("longest match", e);
    endtask

    task automatic test_update_replace();
        int e;
        int hi;
        int lo;
        int r;
        e = errors;
        present_packet(mk_data(PATH, 6'd16, 8'h30, 8'h2F), ACCEPT);
        lookup_check(mk_name(PATH, 6'd20), 1'b0);
        repeat (10) begin
            hi = $random(seed);
            lo = $random(seed);
            r  = $random(seed);
            present_packet(mk_data({hi, lo}, r[5:0], r[15:8], r[23:16]), ACCEPT);
        end
        for (int i = 0; i < `FIB_DEPTH; i++) begin
            lookup_check(mk_name(m_prefix[i], 6'd63), 1'b0);
        end
        close_test("update and replacement", e);
    endtask

    task automatic test_busy_rule();
        int e;
        e = errors;
        present_packet(mk_data(64'h7777_0000_0000_0000, 6'd32, 8'h40, 8'h44), ACCEPT);
        lookup_check(mk_name(64'h7777_0000_1234_5678, 6'd63), 1'b1);
        if (longest_match.face !== 8'h44)
            report_mismatch("longest_match.face", 128'(8'h44), 128'(longest_match.face));
        close_test("busy rule", e);
    endtask

    initial begin
        seed              = 32'ha697_404d;
        reset             = 1'b1;
        fib_out_bit       = 1'b0;
        pit_in_name       = '0;
        data_ready        = 1'b0;
        data_in           = '0;
        rejected          = 1'b0;
        start_send_to_pit = 1'b0;
        errors            = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        m_victim          = 0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        test_empty_lookup();
        test_pit_presentation();
        test_learned_route();
        test_longest_match();
        test_update_replace();
        test_busy_rule();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fib_forwarding.f ====
+incdir+logic
logic/fib_pkg.sv
logic/fib_route_table.sv
logic/fib_lpm_search.sv
logic/fib_data_stage.sv
logic/fib_top.sv
verification/fib_sva.sv
verification/fib_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fib_tb
FILELIST  ?= fib_forwarding.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
